// ==== axi2wb_pkg.sv ====
// Widths, FIFO depth, AXI burst and response codes
// Byte-lane view of one data word
package axi2wb_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////////////////////
	localparam int ADDR_W	= 16;		// AXI byte address
	localparam int WB_AW	= ADDR_W - 2;	// Wishbone word address
	localparam int DATA_W	= 32;
	localparam int SEL_W	= DATA_W / 8;	// Byte lanes
	localparam int ID_W	= 4;

	// Beat FIFO holds 1<<LG_FIFO entries
	localparam int LG_FIFO	= 3;

	////////////////////////////////////////////////////////////////////////////
	// AXI codes
	////////////////////////////////////////////////////////////////////////////
	localparam logic [1:0] BURST_FIXED	= 2'b00;
	localparam logic [1:0] BURST_INCR	= 2'b01;
	localparam logic [1:0] BURST_WRAP	= 2'b10;

	localparam logic [1:0] RESP_OKAY	= 2'b00;
	localparam logic [1:0] RESP_SLVERR	= 2'b10;

	// One data word, seen whole or lane by lane
	typedef union packed
	{
		logic [DATA_W-1:0]		word;
		logic [SEL_W-1:0][7:0]	bytes;	// bytes[0] is the low lane
	} data_lane_u;

endpackage

// ==== beat_if.sv ====
// One write beat on its way to Wishbone, with burst tags
// Modports for the producer, both FIFO sides and the consumer
`timescale 1ns/1ns

interface beat_if;
	import axi2wb_pkg::*;

	logic			valid;
	logic			ready;
	logic [WB_AW-1:0]	addr;	// Word address
	logic [DATA_W-1:0]	data;	// Already in Wishbone lane order
	logic [SEL_W-1:0]	sel;
	logic [ID_W-1:0]	id;	// AWID of the owning burst
	logic			last;	// Final beat by AWLEN

	// A beat moves when valid and ready are both high
	modport src (output valid, addr, data, sel, id, last,
		input ready);

	modport buf_in (input valid, addr, data, sel, id, last,
		output ready);

	modport buf_out (output valid, addr, data, sel, id, last,
		input ready);

	modport dst (input valid, addr, data, sel, id, last,
		output ready);

endinterface

// ==== axi_wr_burst.sv ====
// AXI write burst front end: AW/W acceptance, beat address generation
// and little to big endian lane swap into the beat stream
`timescale 1ns/1ns

module axi_wr_burst (
	input	logic				S_AXI_ACLK,
	input	logic				S_AXI_ARESETN,
	// AW channel
	input	logic				i_awvalid,
	output	logic				o_awready,
	input	logic [axi2wb_pkg::ID_W-1:0]	i_awid,
	input	logic [axi2wb_pkg::ADDR_W-1:0]	i_awaddr,
	input	logic [7:0]			i_awlen,
	input	logic [1:0]			i_awburst,
	// W channel
	input	logic				i_wvalid,
	output	logic				o_wready,
	input	logic [axi2wb_pkg::DATA_W-1:0]	i_wdata,
	input	logic [axi2wb_pkg::SEL_W-1:0]	i_wstrb,
	// Beats toward the FIFO
	beat_if.src				beat
);
	import axi2wb_pkg::*;

	logic			busy;		// Burst accepted, beats pending
	logic [ID_W-1:0]	burst_id;
	logic [ADDR_W-1:0]	burst_addr;	// Address of the next beat
	logic [7:0]		burst_len;
	logic [1:0]		burst_type;
	logic [7:0]		beat_cnt;	// Beats left after this one

	logic			slot_free;
	logic			aw_fire, w_fire;
	logic [ADDR_W-1:0]	incr_addr, next_addr, wrap_mask;
	data_lane_u		wr_lane, wb_lane;
	logic [SEL_W-1:0]	wb_sel;

	assign slot_free = !beat.valid || beat.ready;	// Empty or drains now
	assign o_awready = !busy;
	assign o_wready  = busy && slot_free;
	assign aw_fire   = i_awvalid && o_awready;
	assign w_fire    = i_wvalid && o_wready;

	////////////////////////////////////////////////////////////////////////////
	// Next beat address
	////////////////////////////////////////////////////////////////////////////

	// Window of (len+1)*4 bytes, len is 1, 3, 7 or 15 for WRAP
	assign wrap_mask = {{(ADDR_W-10){1'b0}}, burst_len, 2'b11};

	always_comb
	begin
		incr_addr = burst_addr + ADDR_W'(4);
		case (burst_type)
		BURST_FIXED:	next_addr = burst_addr;
		BURST_WRAP:	next_addr = (burst_addr & ~wrap_mask)
					| (incr_addr & wrap_mask);
		default:	next_addr = incr_addr;	// INCR and reserved
		endcase
	end

	// Reverse lane order, AXI byte 0 lands on Wishbone lane 3
	always_comb
	begin
		wr_lane.word = i_wdata;
		for (int i = 0; i < SEL_W; i++)
		begin
			wb_lane.bytes[i] = wr_lane.bytes[SEL_W-1-i];
			wb_sel[i] = i_wstrb[SEL_W-1-i];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
	begin
		busy <= 1'b0;
		beat.valid <= 1'b0;
	end else begin
		if (aw_fire)
			busy <= 1'b1;
		else if (w_fire && beat_cnt == 8'd0)
			busy <= 1'b0;		// Count ends the burst, not WLAST

		if (w_fire)
			beat.valid <= 1'b1;
		else if (beat.ready)
			beat.valid <= 1'b0;
	end

	// Burst registers
	always_ff @(posedge S_AXI_ACLK)
	if (aw_fire)
	begin
		burst_id   <= i_awid;
		burst_addr <= i_awaddr;
		burst_len  <= i_awlen;
		burst_type <= i_awburst;
		beat_cnt   <= i_awlen;
	end else if (w_fire)
	begin
		burst_addr <= next_addr;
		beat_cnt   <= beat_cnt - 8'd1;
	end

	// Output slot payload
	always_ff @(posedge S_AXI_ACLK)
	if (w_fire)
	begin
		beat.addr <= burst_addr[ADDR_W-1:2];
		beat.data <= wb_lane.word;
		beat.sel  <= wb_sel;
		beat.id   <= burst_id;
		beat.last <= (beat_cnt == 8'd0);
	end

endmodule

// ==== beat_fifo.sv ====
// Show-ahead beat FIFO between the AXI front end and the Wishbone master
`timescale 1ns/1ns

module beat_fifo (
	input	logic	S_AXI_ACLK,
	input	logic	S_AXI_ARESETN,
	beat_if.buf_in	push,
	beat_if.buf_out	pop
);
	import axi2wb_pkg::*;

	// Storage, one array per beat field
	logic [WB_AW-1:0]	mem_addr [0:(1<<LG_FIFO)-1];
	logic [DATA_W-1:0]	mem_data [0:(1<<LG_FIFO)-1];
	logic [SEL_W-1:0]	mem_sel  [0:(1<<LG_FIFO)-1];
	logic [ID_W-1:0]	mem_id   [0:(1<<LG_FIFO)-1];
	logic			mem_last [0:(1<<LG_FIFO)-1];

	logic [LG_FIFO:0]	wr_ptr, rd_ptr;	// Top bit is the wrap bit
	logic			full, empty;
	logic			do_push, do_pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[LG_FIFO] != rd_ptr[LG_FIFO])
		&& (wr_ptr[LG_FIFO-1:0] == rd_ptr[LG_FIFO-1:0]);

	assign push.ready = !full;
	assign do_push = push.valid && !full;
	assign do_pop  = pop.ready && !empty;

	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
	begin
		wr_ptr <= '0;
		rd_ptr <= '0;
	end else begin
		if (do_push)
			wr_ptr <= wr_ptr + 1'b1;
		if (do_pop)
			rd_ptr <= rd_ptr + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	if (do_push)
	begin
		mem_addr[wr_ptr[LG_FIFO-1:0]] <= push.addr;
		mem_data[wr_ptr[LG_FIFO-1:0]] <= push.data;
		mem_sel[wr_ptr[LG_FIFO-1:0]]  <= push.sel;
		mem_id[wr_ptr[LG_FIFO-1:0]]   <= push.id;
		mem_last[wr_ptr[LG_FIFO-1:0]] <= push.last;
	end

	// Head entry is always on the output
	assign pop.valid = !empty;
	assign pop.addr  = mem_addr[rd_ptr[LG_FIFO-1:0]];
	assign pop.data  = mem_data[rd_ptr[LG_FIFO-1:0]];
	assign pop.sel   = mem_sel[rd_ptr[LG_FIFO-1:0]];
	assign pop.id    = mem_id[rd_ptr[LG_FIFO-1:0]];
	assign pop.last  = mem_last[rd_ptr[LG_FIFO-1:0]];

endmodule

// ==== wb_wr_master.sv ====
// Pipelined Wishbone write master fed from the beat FIFO
// Ack counting, error drain and the single AXI B response register
`timescale 1ns/1ns

module wb_wr_master (
	input	logic				S_AXI_ACLK,
	input	logic				S_AXI_ARESETN,
	beat_if.dst				beat,
	// Wishbone
	output	logic				o_wb_cyc,
	output	logic				o_wb_stb,
	output	logic [axi2wb_pkg::WB_AW-1:0]	o_wb_addr,
	output	logic [axi2wb_pkg::DATA_W-1:0]	o_wb_data,
	output	logic [axi2wb_pkg::SEL_W-1:0]	o_wb_sel,
	input	logic				i_wb_stall,
	input	logic				i_wb_ack,
	input	logic				i_wb_err,
	// AXI B channel
	output	logic				o_bvalid,
	input	logic				i_bready,
	output	logic [axi2wb_pkg::ID_W-1:0]	o_bid,
	output	logic [1:0]			o_bresp
);
	import axi2wb_pkg::*;

	logic [8:0]	ack_cnt;	// Issued beats not yet acked, up to 256
	logic [8:0]	ack_cnt_next;
	logic		last_issued;	// Burst's last beat has left the FIFO
	logic		err_flag;	// Sticky, puts the burst in drain mode

	logic		stb_free;
	logic		wb_fail, ack_in;
	logic		issue, drain_pop;
	logic		burst_done, b_fire;

	assign stb_free = !o_wb_stb || !i_wb_stall;
	assign wb_fail  = o_wb_cyc && i_wb_err;
	assign ack_in   = o_wb_cyc && i_wb_ack;	// Acks outside cyc are stale
	assign b_fire   = o_bvalid && i_bready;

	// New strobe only between bursts' responses and outside error mode
	assign issue = beat.valid && stb_free && !o_bvalid
		&& !last_issued && !err_flag && !wb_fail;

	// Rest of an errored burst leaves the FIFO without strobes
	assign drain_pop = beat.valid && err_flag && !last_issued;

	assign beat.ready = issue || drain_pop;

	always_comb
	begin
		if (wb_fail)
			ack_cnt_next = 9'd0;
		else
			ack_cnt_next = ack_cnt + {8'd0, issue} - {8'd0, ack_in};
	end

	// Errored bursts finish once drained, clean ones on the final ack
	assign burst_done = last_issued && !o_bvalid
		&& (err_flag || (!wb_fail && ack_cnt_next == 9'd0));

	////////////////////////////////////////////////////////////////////////////
	// Bus cycle
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
	begin
		o_wb_cyc <= 1'b0;
		o_wb_stb <= 1'b0;
		ack_cnt  <= 9'd0;
	end else begin
		ack_cnt  <= ack_cnt_next;
		o_wb_cyc <= !wb_fail && (ack_cnt_next != 9'd0);

		if (wb_fail)
			o_wb_stb <= 1'b0;	// Error ends the cycle
		else if (stb_free)
			o_wb_stb <= issue;
	end

	// Request payload, held while stalled
	always_ff @(posedge S_AXI_ACLK)
	if (issue)
	begin
		o_wb_addr <= beat.addr;
		o_wb_data <= beat.data;
		o_wb_sel  <= beat.sel;
	end

	////////////////////////////////////////////////////////////////////////////
	// Burst tracking and response
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK)
	if (!S_AXI_ARESETN)
	begin
		last_issued <= 1'b0;
		err_flag    <= 1'b0;
		o_bvalid    <= 1'b0;
	end else begin
		if (b_fire)
		begin
			last_issued <= 1'b0;
			err_flag    <= 1'b0;
		end else begin
			if ((issue || drain_pop) && beat.last)
				last_issued <= 1'b1;
			if (wb_fail)
				err_flag <= 1'b1;
		end

		if (burst_done)
			o_bvalid <= 1'b1;
		else if (i_bready)
			o_bvalid <= 1'b0;
	end

	// ID follows each popped beat, frozen while the response waits
	always_ff @(posedge S_AXI_ACLK)
	if (issue || drain_pop)
		o_bid <= beat.id;

	always_ff @(posedge S_AXI_ACLK)
	if (burst_done)
		o_bresp <= err_flag ? RESP_SLVERR : RESP_OKAY;

endmodule

// ==== axi2wb_wr_top.sv ====
// AXI4 write channels to pipelined Wishbone write bridge, top level
// Front end, beat FIFO and Wishbone master joined by two beat streams
`timescale 1ns/1ns

module axi2wb_wr_top (
	input	logic				S_AXI_ACLK,
	input	logic				S_AXI_ARESETN,
	// AW
	input	logic				i_awvalid,
	output	logic				o_awready,
	input	logic [axi2wb_pkg::ID_W-1:0]	i_awid,
	input	logic [axi2wb_pkg::ADDR_W-1:0]	i_awaddr,
	input	logic [7:0]			i_awlen,
	input	logic [1:0]			i_awburst,
	// W
	input	logic				i_wvalid,
	output	logic				o_wready,
	input	logic [axi2wb_pkg::DATA_W-1:0]	i_wdata,
	input	logic [axi2wb_pkg::SEL_W-1:0]	i_wstrb,
	input	logic				i_wlast,	// Beat count comes from AWLEN
	// B
	output	logic				o_bvalid,
	input	logic				i_bready,
	output	logic [axi2wb_pkg::ID_W-1:0]	o_bid,
	output	logic [1:0]			o_bresp,
	// Wishbone
	output	logic				o_wb_cyc,
	output	logic				o_wb_stb,
	output	logic [axi2wb_pkg::WB_AW-1:0]	o_wb_addr,
	output	logic [axi2wb_pkg::DATA_W-1:0]	o_wb_data,
	output	logic [axi2wb_pkg::SEL_W-1:0]	o_wb_sel,
	input	logic				i_wb_stall,
	input	logic				i_wb_ack,
	input	logic				i_wb_err
);

	beat_if prod_beat();	// Front end to FIFO
	beat_if cons_beat();	// FIFO to Wishbone master

	axi_wr_burst u_burst (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.i_awvalid	(i_awvalid),
		.o_awready	(o_awready),
		.i_awid		(i_awid),
		.i_awaddr	(i_awaddr),
		.i_awlen	(i_awlen),
		.i_awburst	(i_awburst),
		.i_wvalid	(i_wvalid),
		.o_wready	(o_wready),
		.i_wdata	(i_wdata),
		.i_wstrb	(i_wstrb),
		.beat		(prod_beat)
	);

	beat_fifo u_fifo (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.push		(prod_beat),
		.pop		(cons_beat)
	);

	wb_wr_master u_master (
		.S_AXI_ACLK	(S_AXI_ACLK),
		.S_AXI_ARESETN	(S_AXI_ARESETN),
		.beat		(cons_beat),
		.o_wb_cyc	(o_wb_cyc),
		.o_wb_stb	(o_wb_stb),
		.o_wb_addr	(o_wb_addr),
		.o_wb_data	(o_wb_data),
		.o_wb_sel	(o_wb_sel),
		.i_wb_stall	(i_wb_stall),
		.i_wb_ack	(i_wb_ack),
		.i_wb_err	(i_wb_err),
		.o_bvalid	(o_bvalid),
		.i_bready	(i_bready),
		.o_bid		(o_bid),
		.o_bresp	(o_bresp)
	);

endmodule

// ==== axi2wb_wr_asserts.sv ====
// Concurrent Wishbone and AXI protocol checks, bound to the bridge top level
`timescale 1ns/1ns

module axi2wb_wr_asserts (
	input	logic				S_AXI_ACLK,
	input	logic				S_AXI_ARESETN,
	input	logic				i_awready,
	input	logic				i_wready,
	input	logic				i_bvalid,
	input	logic				i_bready,
	input	logic [axi2wb_pkg::ID_W-1:0]	i_bid,
	input	logic [1:0]			i_bresp,
	input	logic				i_wb_cyc,
	input	logic				i_wb_stb,
	input	logic [axi2wb_pkg::WB_AW-1:0]	i_wb_addr,
	input	logic [axi2wb_pkg::DATA_W-1:0]	i_wb_data,
	input	logic				i_wb_stall,
	input	logic				i_wb_err
);

	stb_in_cyc: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		i_wb_stb |-> i_wb_cyc)
		else $error("Wishbone strobe outside a bus cycle");

	// Error ends the cycle, so a stalled request may drop then
	stall_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(i_wb_stb && i_wb_stall && !i_wb_err)
		|=> (i_wb_stb && $stable(i_wb_addr) && $stable(i_wb_data)))
		else $error("Wishbone request changed while stalled");

	b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(i_bvalid && !i_bready) |=> (i_bvalid && $stable(i_bid) && $stable(i_bresp)))
		else $error("B response dropped or changed before BREADY");

	aw_w_apart: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		!(i_awready && i_wready))
		else $error("AWREADY and WREADY high together");

endmodule

bind axi2wb_wr_top axi2wb_wr_asserts u_asserts (
	.S_AXI_ACLK	(S_AXI_ACLK),
	.S_AXI_ARESETN	(S_AXI_ARESETN),
	.i_awready	(o_awready),
	.i_wready	(o_wready),
	.i_bvalid	(o_bvalid),
	.i_bready	(i_bready),
	.i_bid		(o_bid),
	.i_bresp	(o_bresp),
	.i_wb_cyc	(o_wb_cyc),
	.i_wb_stb	(o_wb_stb),
	.i_wb_addr	(o_wb_addr),
	.i_wb_data	(o_wb_data),
	.i_wb_stall	(i_wb_stall),
	.i_wb_err	(i_wb_err)
);

// ==== axi2wb_wr_tb.sv ====
// Testbench for the AXI4 write to Wishbone bridge
// Random bursts, Wishbone slave model, reference queues and checks
`timescale 1ns/1ns

module axi2wb_wr_tb;
	import axi2wb_pkg::*;

	localparam int N_BURSTS = 40;
	localparam int MAX_CYCLES = N_BURSTS * 16 * 24 + 2000;	// Up to 16 beats under heavy stall
	localparam logic [31:0] SEED = 32'ha523;

	logic			aclk = 1'b0;
	logic			aresetn, awvalid, awready, wvalid, wready, wlast;
	logic [ID_W-1:0]	awid, bid;
	logic [ADDR_W-1:0]	awaddr;
	logic [7:0]		awlen;
	logic [1:0]		awburst, bresp;
	logic [DATA_W-1:0]	wdata, wb_data;
	logic [SEL_W-1:0]	wstrb, wb_sel;
	logic			bvalid, bready, wb_cyc, wb_stb, wb_stall, wb_ack, wb_err;
	logic [WB_AW-1:0]	wb_addr;

	// Reference model with one entry per beat and per burst
	logic [WB_AW-1:0]	exp_addr [$];
	logic [DATA_W-1:0]	exp_data [$];
	logic [SEL_W-1:0]	exp_sel [$];
	logic [ID_W-1:0]	exp_id [$];
	int			exp_beats [$];
	int			resp_due [$];	// Slave cycle for each pending response

	int		cycle = 0;
	int		seen = 0;		// Strobes of the burst in flight
	bit		err_seen = 1'b0;
	int		done_bursts = 0;
	int		strobe_total = 0;
	int		expect_total = 0;
	logic [31:0]	stim_state = SEED;
	logic [31:0]	bus_state = SEED ^ 32'h5a5a;
	logic [31:0]	delay_state = SEED ^ 32'h3c3c;

	always #4 aclk = ~aclk;

	axi2wb_wr_top uut (
		.S_AXI_ACLK(aclk), .S_AXI_ARESETN(aresetn),
		.i_awvalid(awvalid), .o_awready(awready), .i_awid(awid),
		.i_awaddr(awaddr), .i_awlen(awlen), .i_awburst(awburst),
		.i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
		.i_wstrb(wstrb), .i_wlast(wlast),
		.o_bvalid(bvalid), .i_bready(bready), .o_bid(bid), .o_bresp(bresp),
		.o_wb_cyc(wb_cyc), .o_wb_stb(wb_stb), .o_wb_addr(wb_addr),
		.o_wb_data(wb_data), .o_wb_sel(wb_sel), .i_wb_stall(wb_stall),
		.i_wb_ack(wb_ack), .i_wb_err(wb_err)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int pick(input logic [31:0] s, input int n);
		return int'(s[30:16]) % n;	// Upper bits as the low ones repeat quickly
	endfunction

	// AXI byte 0 belongs on the top Wishbone lane
	function automatic logic [DATA_W-1:0] swap_bytes(input logic [DATA_W-1:0] d);
		return {d[7:0], d[15:8], d[23:16], d[31:24]};
	endfunction

	function automatic logic [SEL_W-1:0] swap_strb(input logic [SEL_W-1:0] s);
		return {s[0], s[1], s[2], s[3]};
	endfunction

	function automatic logic [ADDR_W-1:0] next_beat_addr(input logic [ADDR_W-1:0] a,
		input logic [1:0] kind, input logic [7:0] len);
		logic [ADDR_W-1:0] span, base, step;
		span = ADDR_W'((int'(len) + 1) * 4);
		base = a - (a % span);
		step = a + ADDR_W'(4);
		if (kind == BURST_FIXED)
			return a;
		else if (kind == BURST_WRAP && step == base + span)
			return base;	// Past the window top so back to its start
		return step;
	endfunction

	task automatic report_failure(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1, "stopped at first failing check");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// AXI master started on a falling edge
	////////////////////////////////////////////////////////////////////////////
	task automatic run_burst();
		logic [1:0]		kind;
		logic [7:0]		len;
		logic [ADDR_W-1:0]	a;
		logic [DATA_W-1:0]	d;
		logic [SEL_W-1:0]	s;
		stim_state = lcg_step(stim_state);
		kind = (pick(stim_state, 3) == 0) ? BURST_FIXED
			: (pick(stim_state, 3) == 1) ? BURST_INCR : BURST_WRAP;
		stim_state = lcg_step(stim_state);
		len = (kind == BURST_WRAP) ? 8'((2 << pick(stim_state, 4)) - 1)
			: 8'(pick(stim_state, 16));
		stim_state = lcg_step(stim_state);
		a = {stim_state[31:18], 2'b00};
		exp_id.push_back(stim_state[17:14]);
		exp_beats.push_back(int'(len) + 1);
		awvalid = 1'b1;
		awid = stim_state[17:14];
		awaddr = a;
		awlen = len;
		awburst = kind;
		@(posedge aclk);
		while (!awready)
			@(posedge aclk);
		@(negedge aclk);
		awvalid = 1'b0;
		for (int i = 0; i <= int'(len); i++)
		begin
			stim_state = lcg_step(stim_state);
			d = stim_state;
			stim_state = lcg_step(stim_state);
			s = stim_state[19:16];
			exp_addr.push_back(a[ADDR_W-1:2]);
			exp_data.push_back(swap_bytes(d));
			exp_sel.push_back(swap_strb(s));
			a = next_beat_addr(a, kind, len);
			stim_state = lcg_step(stim_state);
			while (pick(stim_state, 4) == 0)	// Idle gap
			begin
				wvalid = 1'b0;
				@(negedge aclk);
				stim_state = lcg_step(stim_state);
			end
			wvalid = 1'b1;
			wdata = d;
			wstrb = s;
			wlast = (i == int'(len));
			@(posedge aclk);
			while (!wready)
				@(posedge aclk);
			@(negedge aclk);
		end
		wvalid = 1'b0;
	endtask

	// Wishbone slave and B ready driven on the falling edge
	always @(negedge aclk)
	begin
		bus_state = lcg_step(bus_state);
		wb_stall = (pick(bus_state, 4) == 0);
		bus_state = lcg_step(bus_state);
		bready = (pick(bus_state, 3) != 0);
		wb_ack = 1'b0;
		wb_err = 1'b0;
		if (!wb_cyc)
			resp_due.delete();		// Cycle over so nothing is left to answer
		else if (resp_due.size() > 0 && resp_due[0] <= cycle)
		begin
			void'(resp_due.pop_front());
			bus_state = lcg_step(bus_state);
			wb_err = (pick(bus_state, 40) == 0);
			wb_ack = !wb_err;
			if (wb_err)
				resp_due.delete();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Monitor and reference checks
	////////////////////////////////////////////////////////////////////////////
	always @(posedge aclk)
	if (aresetn)
	begin : monitor
		int due;
		cycle = cycle + 1;
		if (wb_stb && !wb_stall)
		begin
			assert (!err_seen) else report_failure("strobe issued after a bus error");
			assert (exp_addr.size() > 0) else report_failure("strobe with no beat expected");
			assert (wb_addr == exp_addr[0]) else report_failure(
				$sformatf("wb_addr %h, expected %h", wb_addr, exp_addr[0]));
			assert (wb_data == exp_data[0]) else report_failure(
				$sformatf("wb_data %h, expected %h", wb_data, exp_data[0]));
			assert (wb_sel == exp_sel[0]) else report_failure(
				$sformatf("wb_sel %b, expected %b", wb_sel, exp_sel[0]));
			void'(exp_addr.pop_front());
			void'(exp_data.pop_front());
			void'(exp_sel.pop_front());
			seen = seen + 1;
			strobe_total = strobe_total + 1;
			delay_state = lcg_step(delay_state);
			due = cycle + pick(delay_state, 3);
			if (resp_due.size() > 0 && due <= resp_due[$])
				due = resp_due[$] + 1;	// One response per cycle and in order
			resp_due.push_back(due);
		end
		if (wb_cyc && wb_err)
			err_seen = 1'b1;
		if (bvalid && bready)
		begin
			assert (exp_id.size() > 0) else report_failure("B response with no burst open");
			assert (bid == exp_id[0]) else report_failure(
				$sformatf("bid %h, expected %h", bid, exp_id[0]));
			assert (bresp == (err_seen ? RESP_SLVERR : RESP_OKAY)) else report_failure(
				$sformatf("bresp %b after bus error flag %0b", bresp, err_seen));
			assert (err_seen ? seen <= exp_beats[0] : seen == exp_beats[0])
				else report_failure($sformatf("%0d strobes for a %0d beat burst",
				seen, exp_beats[0]));
			expect_total = expect_total + (err_seen ? seen : exp_beats[0]);
			for (int k = seen; k < exp_beats[0]; k++)
			begin
				void'(exp_addr.pop_front());	// Drained without strobes
				void'(exp_data.pop_front());
				void'(exp_sel.pop_front());
			end
			void'(exp_id.pop_front());
			void'(exp_beats.pop_front());
			seen = 0;
			err_seen = 1'b0;
			done_bursts = done_bursts + 1;
		end
	end

	initial
	begin
		aresetn = 1'b0;
		awvalid = 1'b0;
		awid = '0;
		awaddr = '0;
		awlen = '0;
		awburst = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wlast = 1'b0;
		bready = 1'b0;
		wb_stall = 1'b0;
		wb_ack = 1'b0;
		wb_err = 1'b0;
		repeat (4) @(posedge aclk);
		@(negedge aclk);
		aresetn = 1'b1;
		assert (awready && !wready && !wb_cyc && !wb_stb && !bvalid)
			else report_failure("outputs not in their reset state");
		for (int n = 0; n < N_BURSTS; n++)
			run_burst();
		wait (done_bursts == N_BURSTS);
		repeat (4) @(posedge aclk);
		assert (strobe_total == expect_total) else report_failure(
			$sformatf("%0d strobes, expected %0d", strobe_total, expect_total));
		assert (exp_addr.size() == 0) else report_failure("beats left in the model");
		$display("Done: no errors");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (MAX_CYCLES) @(posedge aclk);
		$display("Timeout: only %0d of %0d bursts got a response", done_bursts, N_BURSTS);
		$display("Done: errors found");
		$fatal(1, "simulation hung");
	end

endmodule

// ==== filelist.f ====
axi2wb_pkg.sv
beat_if.sv
axi_wr_burst.sv
beat_fifo.sv
wb_wr_master.sv
axi2wb_wr_top.sv
axi2wb_wr_asserts.sv
axi2wb_wr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI to Wishbone write bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module axi2wb_wr_tb -f filelist.f -o sim_axi2wb

./obj_dir/sim_axi2wb 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log || ! grep -q "Done: no errors" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation passed"
